// File: Bender.yml
package:
  name: adc_uart

sources:
  - files:
      - rtl/adc_uart_pkg.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/adc_spi_reader.sv
      - rtl/sample_sequencer.sv
      - rtl/adc_uart_top.sv
  - target: test
    files:
      - dv/adc_uart_sva.sv
      - dv/tb_adc_uart_top.sv

// File: dv/adc_uart_sva.sv
`timescale 1ns/1ps
`default_nettype none

module adc_uart_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     adc1_cs,
    input logic                     adc1_sclk,
    input logic                     adc2_cs,
    input logic                     adc2_sclk,
    input logic                     uart_tx_line,
    input logic                     tx_start,
    input logic                     tx_busy,
    input adc_uart_pkg::uart_byte_t rx_data,
    input logic                     rx_done,
    input logic                     frame_error
);
    int fail_count = 0;

    // sclk rests high whenever its ADC is deselected
    a_adc1_sclk_idle: assert property (@(posedge clk) disable iff (rst) adc1_cs |-> adc1_sclk)
        else begin
            $error("adc1_sclk left its idle level while adc1_cs was high");
            fail_count++;
        end

    a_adc2_sclk_idle: assert property (@(posedge clk) disable iff (rst) adc2_cs |-> adc2_sclk)
        else begin
            $error("adc2_sclk left its idle level while adc2_cs was high");
            fail_count++;
        end

    // Start only while idle, then busy and the start bit on the line one cycle later
    a_tx_handshake: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !tx_busy ##1 (tx_busy && !uart_tx_line))
        else begin
            $error("tx_start sent while busy, or no start bit in the cycle after it");
            fail_count++;
        end

    // A rejected byte is neither delivered nor written to rx_data
    a_rx_discard: assert property (@(posedge clk) disable iff (rst)
        frame_error |-> !rx_done && (rx_data === $past(rx_data)))
        else begin
            $error("a byte with a low stop bit was delivered by the receiver");
            fail_count++;
        end

endmodule

bind adc_uart_top adc_uart_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .adc1_cs      (adc1_cs),
    .adc1_sclk    (adc1_sclk),
    .adc2_cs      (adc2_cs),
    .adc2_sclk    (adc2_sclk),
    .uart_tx_line (uart_tx_line),
    .tx_start     (tx_start),
    .tx_busy      (tx_busy),
    .rx_data      (rx_data),
    .rx_done      (rx_done),
    .frame_error  (frame_error)
);

`default_nettype wire

// File: dv/tb_adc_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

// Serial ADC, new random result per conversion
module adc_model (
    input  logic cs,
    input  logic sclk,
    output logic sdo
);
    import adc_uart_pkg::*;

    adc_sample_t served[$];
    adc_sample_t cur;
    int bit_idx;

    initial sdo = 1'b0;

    always @(negedge cs) begin
        cur = adc_sample_t'($urandom);
        served.push_back(cur);
        bit_idx = 0;
    end

    // Leading zeros, then the result MSB first
    always @(negedge sclk) begin
        if (!cs) begin
            #1;
            sdo = (bit_idx < ADC_LEAD_ZEROS) ? 1'b0 : cur[ADC_FRAME_BITS - 1 - bit_idx];
            bit_idx++;
        end
    end
endmodule

module tb_adc_uart_top;
    import adc_uart_pkg::*;

    localparam logic [31:0] SEED = 32'h32d7_c27f;
    // One read plus three bytes, with slack
    localparam int LATE_LIMIT = ADC_FRAME_BITS * 2 * SCLK_HALF + 2 + 34 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 20 * SAMPLE_PERIOD + 12 * CLKS_PER_BIT + LATE_LIMIT;

    logic clk = 1'b0;
    logic rst;
    logic uart_rx_line;
    logic uart_tx_line;
    logic adc1_sdo, adc2_sdo;
    logic adc1_cs, adc1_sclk, adc2_cs, adc2_sclk;
    int cycle = 0;
    int frame_count = 0;
    int conversions = 0;
    string test_name = "reset";

    adc_uart_top u_dut (.*);
    adc_model u_adc1_model (.cs(adc1_cs), .sclk(adc1_sclk), .sdo(adc1_sdo));
    adc_model u_adc2_model (.cs(adc2_cs), .sclk(adc2_sclk), .sdo(adc2_sdo));

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected, actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch in %s, %s: expected 'h%0h, actual 'h%0h",
                test_name, what, expected, actual));
        end
    endtask

    task automatic wait_frames(input int n);
        while (frame_count < n) @(negedge clk);
    endtask

    // 8N1 byte into the receiver, then two idle bit times
    task automatic send_uart_byte(input uart_byte_t data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 uart_rx_line = bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        #1 uart_rx_line = 1'b1;
        repeat (2 * CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) fail_run("timeout: the run did not finish in time");
    end

    // Protocol checker failures end the run at once
    always @(negedge clk) begin
        if (u_dut.u_sva.fail_count != 0) fail_run("a protocol assertion failed");
    end

    always @(negedge adc1_cs) conversions++;

    // Decode uart_tx_line at bit centers and compare whole frames
    initial begin : uart_monitor
        uart_byte_t rx_byte;
        uart_byte_t bytes[$];
        adc_sample_t a1, a2;
        forever begin
            @(negedge uart_tx_line);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (uart_tx_line !== 1'b0) fail_run("start bit on uart_tx_line did not hold");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[i] = uart_tx_line;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (uart_tx_line !== 1'b1) fail_run("stop bit on uart_tx_line was low");
            bytes.push_back(rx_byte);
            if (bytes.size() == 3) begin
                if (u_adc1_model.served.size() == 0 || u_adc2_model.served.size() == 0) begin
                    fail_run("a frame arrived with no ADC conversion behind it");
                end
                a1 = u_adc1_model.served.pop_front();
                a2 = u_adc2_model.served.pop_front();
                check_value("frame", {a1[11:4], a1[3:0], a2[11:8], a2[7:0]},
                    {bytes[0], bytes[1], bytes[2]});
                bytes.delete();
                frame_count++;
            end
        end
    end

    initial begin
        int n;
        int start;
        uart_byte_t b;
        void'($urandom(SEED));
        rst = 1'b1;
        uart_rx_line = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("tx line", 1, uart_tx_line);
        check_value("cs lines", 2'b11, {adc1_cs, adc2_cs});
        check_value("sclk lines", 2'b11, {adc1_sclk, adc2_sclk});
        repeat (SAMPLE_PERIOD - 10) @(negedge clk);
        check_value("frames before first period", 0, frame_count);
        check_value("reads before first period", 0, conversions);

        test_name = "periodic";
        wait_frames(8);

        // Sequencer is idle right after a frame
        test_name = "trigger";
        n = frame_count;
        send_uart_byte(TRIGGER_CMD, 1'b1);
        start = cycle;
        wait_frames(n + 1);
        if (cycle - start > LATE_LIMIT) fail_run("the triggered frame came too late");

        // Quiet window after the next periodic frame
        test_name = "ignored bytes";
        wait_frames(frame_count + 1);
        n = conversions;
        for (int i = 0; i < 3; i++) begin
            b = uart_byte_t'($urandom);
            if (b == TRIGGER_CMD) b = b ^ 8'h01;
            send_uart_byte(b, 1'b1);
        end
        send_uart_byte(TRIGGER_CMD, 1'b0);
        send_uart_byte(TRIGGER_CMD, 1'b0);
        repeat (4) @(negedge clk);
        check_value("reads", n, conversions);
        check_value("frames", conversions, frame_count);

        // Trigger lands while the first byte is on the line
        test_name = "back-pressure";
        @(negedge adc1_cs);
        @(negedge uart_tx_line);
        n = frame_count;
        send_uart_byte(TRIGGER_CMD, 1'b1);
        wait_frames(n + 1);
        start = cycle;
        wait_frames(n + 2);
        if (cycle - start > LATE_LIMIT) fail_run("the pending frame came too late");
        repeat (20 * CLKS_PER_BIT) @(negedge clk);
        check_value("frames", n + 2, frame_count);
        check_value("reads", frame_count, conversions);
        check_value("unsent adc1 values", 0, u_adc1_model.served.size());

        if (u_dut.u_sva.fail_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            fail_run("protocol assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: list.f
rtl/adc_uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/adc_spi_reader.sv
rtl/sample_sequencer.sv
rtl/adc_uart_top.sv
dv/adc_uart_sva.sv
dv/tb_adc_uart_top.sv

// File: rtl/adc_spi_reader.sv
`timescale 1ns/1ps
`default_nettype none

module adc_spi_reader #(
    parameter bit SCLK_IDLE = 1'b1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      read_start,
    input  logic                      sdo,
    output logic                      cs,
    output logic                      sclk,
    output adc_uart_pkg::adc_sample_t value,
    output logic                      read_done
);
    import adc_uart_pkg::*;

    logic active;
    logic last;
    logic [$clog2(SCLK_HALF)-1:0] div_cnt;
    logic [$clog2(ADC_FRAME_BITS)-1:0] edge_cnt;
    logic [ADC_FRAME_BITS-1:0] shift_reg;
    logic half_end;
    logic rise;

    assign half_end = active && !last && (div_cnt == SCLK_HALF - 1);
    // Toggle from low is the rising edge, where sdo is taken
    assign rise = half_end && !sclk;

    always_ff @(posedge clk) begin
        read_done <= 1'b0;
        if (rst) begin
            cs       <= 1'b1;
            sclk     <= SCLK_IDLE;
            active   <= 1'b0;
            last     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
        end else if (!active) begin
            // A start while busy falls through here unseen
            if (read_start) begin
                cs       <= 1'b0;
                active   <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= '0;
            end
        end else if (last) begin
            // One cycle after the final rising edge
            cs        <= 1'b1;
            sclk      <= SCLK_IDLE;
            active    <= 1'b0;
            last      <= 1'b0;
            read_done <= 1'b1;
        end else if (half_end) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            if (rise) begin
                edge_cnt <= edge_cnt + 1'b1;
                if (edge_cnt == ADC_FRAME_BITS - 1) begin
                    last <= 1'b1;
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Leading zeros shift out the top, result is the low bits
    always_ff @(posedge clk) begin
        if (rise) begin
            shift_reg <= {shift_reg[ADC_FRAME_BITS-2:0], sdo};
        end
        if (active && last) begin
            value <= shift_reg[ADC_FRAME_BITS-ADC_LEAD_ZEROS-1:0];
        end
    end

endmodule

`default_nettype wire

// File: rtl/adc_uart_pkg.sv
`default_nettype none

package adc_uart_pkg;

    // Widths with a meaning of their own
    typedef logic [11:0] adc_sample_t;
    typedef logic [7:0]  uart_byte_t;

    // UART bit timing, 8N1
    localparam int CLKS_PER_BIT = 16;

    // Serial ADC link
    localparam int SCLK_HALF      = 4;
    localparam int ADC_FRAME_BITS = 16;
    localparam int ADC_LEAD_ZEROS = 4;

    // Periodic sampling and the command that forces a sample
    localparam int         SAMPLE_PERIOD = 2000;
    localparam uart_byte_t TRIGGER_CMD   = 8'h52;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        SEND_BYTE,
        WAIT_TX
    } seq_state_t;

endpackage

`default_nettype wire

// File: rtl/adc_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_uart_top (
    input  logic clk,
    input  logic rst,
    input  logic uart_rx_line,
    output logic uart_tx_line,
    input  logic adc1_sdo,
    input  logic adc2_sdo,
    output logic adc1_cs,
    output logic adc1_sclk,
    output logic adc2_cs,
    output logic adc2_sclk
);
    import adc_uart_pkg::*;

    logic        read_start;
    logic        read_done;
    adc_sample_t adc1_value;
    adc_sample_t adc2_value;
    logic        tx_start;
    uart_byte_t  tx_data;
    logic        tx_busy;
    uart_byte_t  rx_data;
    logic        rx_done;
    // Not used by the design, watched by the protocol checks
    logic        frame_error;

    uart_tx u_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_line  (uart_tx_line),
        .tx_busy  (tx_busy)
    );

    uart_rx u_uart_rx (
        .clk         (clk),
        .rst         (rst),
        .rx_line     (uart_rx_line),
        .rx_data     (rx_data),
        .rx_done     (rx_done),
        .frame_error (frame_error)
    );

    sample_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_done    (rx_done),
        .read_start (read_start),
        .read_done  (read_done),
        .adc1_value (adc1_value),
        .adc2_value (adc2_value),
        .tx_start   (tx_start),
        .tx_data    (tx_data),
        .tx_busy    (tx_busy)
    );

    adc_spi_reader u_adc1 (
        .clk        (clk),
        .rst        (rst),
        .read_start (read_start),
        .sdo        (adc1_sdo),
        .cs         (adc1_cs),
        .sclk       (adc1_sclk),
        .value      (adc1_value),
        .read_done  (read_done)
    );

    // Same timing as reader 1, so its done goes unused
    adc_spi_reader u_adc2 (
        .clk        (clk),
        .rst        (rst),
        .read_start (read_start),
        .sdo        (adc2_sdo),
        .cs         (adc2_cs),
        .sclk       (adc2_sclk),
        .value      (adc2_value),
        .read_done  ()
    );

endmodule

`default_nettype wire

// File: rtl/sample_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  adc_uart_pkg::uart_byte_t  rx_data,
    input  logic                      rx_done,
    output logic                      read_start,
    input  logic                      read_done,
    input  adc_uart_pkg::adc_sample_t adc1_value,
    input  adc_uart_pkg::adc_sample_t adc2_value,
    output logic                      tx_start,
    output adc_uart_pkg::uart_byte_t  tx_data,
    input  logic                      tx_busy
);
    import adc_uart_pkg::*;

    seq_state_t state;
    logic [$clog2(SAMPLE_PERIOD)-1:0] period_cnt;
    logic period_tick;
    logic trigger;
    logic request;
    logic pending;
    logic [1:0] byte_idx;
    // adc1 in the upper half, adc2 in the lower half
    logic [2*$bits(adc_sample_t)-1:0] frame;

    assign period_tick = (period_cnt == SAMPLE_PERIOD - 1);
    assign trigger     = rx_done && (rx_data == TRIGGER_CMD);
    assign request     = period_tick || trigger;

    // Free running, also during a frame
    always_ff @(posedge clk) begin
        if (rst) begin
            period_cnt <= '0;
        end else if (period_tick) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        read_start <= 1'b0;
        tx_start   <= 1'b0;
        if (rst) begin
            state    <= IDLE;
            pending  <= 1'b0;
            byte_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (request || pending) begin
                        read_start <= 1'b1;
                        pending    <= 1'b0;
                        state      <= READ;
                    end
                end
                READ: begin
                    // Readers run in lockstep, reader 1 speaks for both
                    if (read_done) begin
                        byte_idx <= '0;
                        state    <= SEND_BYTE;
                    end
                end
                SEND_BYTE: begin
                    if (!tx_busy) begin
                        tx_start <= 1'b1;
                        state    <= WAIT_TX;
                    end
                end
                WAIT_TX: begin
                    // Busy only shows one cycle after our start pulse
                    if (!tx_start && !tx_busy) begin
                        if (byte_idx == 2'd2) begin
                            state <= IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= SEND_BYTE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase

            // Requests during a busy sequence merge into one
            if (state != IDLE && request) begin
                pending <= 1'b1;
            end
        end
    end

    // Frame capture and byte selection
    always_ff @(posedge clk) begin
        if (state == READ && read_done) begin
            frame <= {adc1_value, adc2_value};
        end
        if (state == SEND_BYTE && !tx_busy) begin
            tx_data <= frame[23:16];
            frame   <= {frame[15:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rx_line,
    output adc_uart_pkg::uart_byte_t rx_data,
    output logic                     rx_done,
    output logic                     frame_error
);
    import adc_uart_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    logic [1:0] sync;
    logic line;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
    logic [2:0] bit_idx;
    uart_byte_t shift_reg;

    // Two-flop synchronizer on the async line
    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 2'b11;
        end else begin
            sync <= {sync[0], rx_line};
        end
    end

    assign line = sync[1];

    always_ff @(posedge clk) begin
        rx_done     <= 1'b0;
        frame_error <= 1'b0;
        if (rst) begin
            state   <= RX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!line) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck at mid start bit, a short glitch goes back to idle
                    if (clk_cnt == CLKS_PER_BIT / 2 - 1) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= line ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == CLKS_PER_BIT - 1) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == CLKS_PER_BIT - 1) begin
                        clk_cnt     <= '0;
                        rx_done     <= line;
                        frame_error <= !line;
                        state       <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && clk_cnt == CLKS_PER_BIT - 1) begin
            shift_reg <= {line, shift_reg[7:1]};
        end
        if (state == RX_STOP && clk_cnt == CLKS_PER_BIT - 1 && line) begin
            rx_data <= shift_reg;
        end
    end

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_start,
    input  adc_uart_pkg::uart_byte_t tx_data,
    output logic                    tx_line,
    output logic                    tx_busy
);
    import adc_uart_pkg::*;

    // Stop, data LSB first, start; bit 0 is on the line
    logic [9:0] shift_reg;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
    logic [3:0] bit_cnt;
    logic bit_end;

    assign bit_end = (clk_cnt == CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            clk_cnt <= '0;
            // Busy drops when the stop bit has run its full length
            if (bit_cnt == $bits(shift_reg) - 1) begin
                tx_busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Data latched at start so the caller may move on
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start) begin
            shift_reg <= {1'b1, tx_data, 1'b0};
        end else if (tx_busy && bit_end) begin
            shift_reg <= {1'b1, shift_reg[9:1]};
        end
    end

    // Line idles high between frames
    assign tx_line = tx_busy ? shift_reg[0] : 1'b1;

endmodule

`default_nettype wire
